// File: tb.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/ctrl_decoder.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/forward_unit.sv
verilog/id_stage.sv
verilog/decode_top.sv
dv/tb_decode_top.sv

// File: dv/tb_decode_top.sv
/*
 * tb_decode_top: random-stimulus testbench for the decode slice. A model of
 * the decode table, register file and stage register is checked every cycle.
 */
`default_nettype none

module tb_decode_top
    import isa_pkg::*;
    import pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            flush;
    inst_u           instruction;
    logic [xlen-1:0] pc;
    fwd_src_t        ex_fwd;
    fwd_src_t        mem_fwd;
    fwd_src_t        wb_wr;
    id_out_t         id_out;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    id_out_t         exp_id;           // model of the stage register
    id_out_t         prev_id;
    logic [xlen-1:0] model_regs [32];
    logic            was_stall;
    logic            was_flush;

    decode_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .instruction (instruction),
        .pc          (pc),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb_wr       (wb_wr),
        .id_out      (id_out),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(input string what, input logic [191:0] got,
                            input logic [191:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic ctrl_t expected_ctrl(input logic [31:0] r);
        ctrl_t      c;
        logic [2:0] f3;
        logic       imm_form;
        logic       word;
        c = '0;
        f3 = r[14:12];
        imm_form = (r[6:0] == op_opimm) || (r[6:0] == op_opimm32);
        word = (r[6:0] == op_op32) || (r[6:0] == op_opimm32);
        case (r[6:0])
            op_op, op_op32, op_opimm, op_opimm32: begin
                c.rf_wr_en = 1'b1;
                c.alu_b_sel = imm_form;
                case (f3)
                    3'd0: begin
                        if (r[30] && !imm_form) c.alu_ctrl = word ? subw : sub;
                        else c.alu_ctrl = word ? addw : add;
                    end
                    3'd1: c.alu_ctrl = sll;
                    3'd2: c.alu_ctrl = slt;
                    3'd3: c.alu_ctrl = sltu;
                    3'd4: c.alu_ctrl = xor_op;
                    3'd5: c.alu_ctrl = r[30] ? sra : srl;  // funct7 bit 5
                    3'd6: c.alu_ctrl = or_op;
                    default: c.alu_ctrl = and_op;
                endcase
            end
            op_load: begin
                c.rf_wr_en = 1'b1;
                c.rf_wr_sel = 2'd1;
                c.alu_b_sel = 1'b1;
                c.alu_ctrl = add;
                c.dm_rd_ctrl = f3 + 3'd1;
            end
            op_store: begin
                c.alu_b_sel = 1'b1;
                c.alu_ctrl = add;
                c.dm_wr_ctrl = f3 + 3'd1;
            end
            op_branch: begin
                c.is_branch = 1'b1;
                c.br_type = f3;
                c.alu_ctrl = sub;
            end
            op_jal, op_jalr: begin
                c.rf_wr_en = 1'b1;
                c.rf_wr_sel = 2'd2;                    // pc + 4
                c.do_jump = 1'b1;
                c.alu_a_sel = (r[6:0] == op_jal);
                c.alu_b_sel = 1'b1;
                c.alu_ctrl = add;
            end
            op_lui: begin
                c.rf_wr_en = 1'b1;
                c.alu_b_sel = 1'b1;
                c.alu_ctrl = pass_b;
            end
            op_auipc: begin
                c.rf_wr_en = 1'b1;
                c.alu_a_sel = 1'b1;
                c.alu_b_sel = 1'b1;
                c.alu_ctrl = add;
            end
            op_system: c.is_debug = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [xlen-1:0] expected_imm(input logic [31:0] r);
        case (r[6:0])
            op_jalr, op_load, op_opimm, op_opimm32, op_system:
                return {{52{r[31]}}, r[31:20]};
            op_store:  return {{52{r[31]}}, r[31:25], r[11:7]};
            op_branch: return {{52{r[31]}}, r[7], r[30:25], r[11:8], 1'b0};
            op_lui, op_auipc: return {{32{r[31]}}, r[31:12], 12'b0};
            op_jal:    return {{44{r[31]}}, r[19:12], r[20], r[30:21], 1'b0};
            default:   return '0;
        endcase
    endfunction

    function automatic id_out_t expected_out(input inst_u i, input logic [xlen-1:0] p);
        id_out_t o;
        o.pc = p;
        o.rd = i.raw[11:7];
        o.rs1 = i.raw[19:15];
        o.rs2 = i.raw[24:20];
        o.imm = expected_imm(i.raw);
        o.ctrl = expected_ctrl(i.raw);
        return o;
    endfunction

    // ex, then mem, then write-through, then the array
    function automatic logic [xlen-1:0] operand_value(input logic [4:0] addr);
        if (addr == 5'd0) return '0;
        if (ex_fwd.wr_en && ex_fwd.rd == addr) return ex_fwd.data;
        if (mem_fwd.wr_en && mem_fwd.rd == addr) return mem_fwd.data;
        if (wb_wr.wr_en && wb_wr.rd == addr) return wb_wr.data;
        return model_regs[addr];
    endfunction

    function automatic inst_u random_inst();
        inst_u i;
        i.raw = $urandom;
        case ($urandom_range(13, 0))
            0: i.raw[6:0] = op_lui;
            1: i.raw[6:0] = op_auipc;
            2: i.raw[6:0] = op_jal;
            3: i.raw[6:0] = op_jalr;
            4: i.raw[6:0] = op_branch;
            5: i.raw[6:0] = op_load;
            6: i.raw[6:0] = op_store;
            7: i.raw[6:0] = op_opimm;
            8: i.raw[6:0] = op_op;
            9: i.raw[6:0] = op_opimm32;
            10: i.raw[6:0] = op_op32;
            11: i.raw[6:0] = op_system;
            default: i.raw[6:0] = 7'($urandom);      // mostly unknown opcodes
        endcase
        i.raw[19:15] = 5'($urandom_range(7, 0));   // small set so addresses collide
        i.raw[24:20] = 5'($urandom_range(7, 0));
        return i;
    endfunction

    task automatic drive_random();
        stall = ($urandom_range(4, 0) == 0);
        flush = ($urandom_range(9, 0) == 0);
        instruction = random_inst();
        pc = {$urandom, $urandom} & ~64'h3;
        ex_fwd.wr_en = ($urandom_range(2, 0) == 0);
        ex_fwd.rd = 5'($urandom_range(7, 0));
        ex_fwd.data = {$urandom, $urandom};
        mem_fwd.wr_en = ($urandom_range(2, 0) == 0);
        mem_fwd.rd = 5'($urandom_range(7, 0));
        mem_fwd.data = {$urandom, $urandom};
        if ($urandom_range(3, 0) == 0) mem_fwd.rd = ex_fwd.rd;
        wb_wr.wr_en = ($urandom_range(1, 0) == 1);
        wb_wr.rd = 5'($urandom_range(7, 0));    // includes x0 attempts
        wb_wr.data = {$urandom, $urandom};
    endtask

    // what the rising edge does to the model
    task automatic update_model();
        if (wb_wr.wr_en && wb_wr.rd != 5'd0) model_regs[wb_wr.rd] = wb_wr.data;
        if (flush) exp_id = '0;
        else if (!stall) exp_id = expected_out(instruction, pc);
        was_stall = stall;
        was_flush = flush;
    endtask

    task automatic wait_for_bubble();
        int n;
        n = 0;
        while (id_out !== '0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (id_out !== '0) begin
            $display("Timeout: id_out never cleared to a bubble after the final flush");
            $display("Errors found");
            $fatal(1);
        end
    endtask

    initial begin
        void'($urandom(63));
        reset = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        instruction = '0;
        pc = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_wr = '0;
        exp_id = '0;
        prev_id = '0;
        was_stall = 1'b0;
        was_flush = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        for (int n = 0; n < 5; n++) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b1;
        #1;
        check_eq("id_out after reset", id_out, '0);
        check_eq("rs1_data after reset", rs1_data, '0);
        check_eq("rs2_data after reset", rs2_data, '0);
        @(posedge clk);
        update_model();

        for (int n = 0; n < 3000; n++) begin
            @(negedge clk);
            check_eq("id_out", id_out, exp_id);
            if (was_flush) check_eq("id_out bubble after flush", id_out, '0);
            else if (was_stall) check_eq("id_out held by stall", id_out, prev_id);
            prev_id = exp_id;
            drive_random();
            #1;
            check_eq("rs1_data", rs1_data, operand_value(exp_id.rs1));
            check_eq("rs2_data", rs2_data, operand_value(exp_id.rs2));
            @(posedge clk);
            update_model();
        end

        @(negedge clk);
        flush = 1'b1;
        stall = 1'b1;                                // flush must still win
        wait_for_bubble();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/decode_top.sv
/*
 * decode_top: instruction decode slice. Connects the stage register, the
 * register file and the operand forwarding.
 */
`default_nettype none

module decode_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              stall,
    input  wire              flush,
    input  wire inst_u       instruction,
    input  wire [xlen-1:0]   pc,
    input  wire fwd_src_t    ex_fwd,
    input  wire fwd_src_t    mem_fwd,
    input  wire fwd_src_t    wb_wr,
    output id_out_t          id_out,
    output logic [xlen-1:0]  rs1_data,
    output logic [xlen-1:0]  rs2_data
);

    logic [xlen-1:0] rf_rs1_data;  // raw array reads
    logic [xlen-1:0] rf_rs2_data;

    id_stage u_id_stage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .instruction (instruction),
        .pc          (pc),
        .id_out      (id_out)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (id_out.rs1),
        .rs2      (id_out.rs2),
        .wb_wr    (wb_wr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data)
    );

    forward_unit u_forward_unit (
        .rs1         (id_out.rs1),
        .rs2         (id_out.rs2),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
/*
 * id_stage: ID/EX stage register. Decodes the incoming instruction,
 * latches control, pc and the instruction word, and handles stall and
 * flush. The immediate is rebuilt from the latched word.
 */
`default_nettype none

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              stall,
    input  wire              flush,
    input  wire inst_u       instruction,
    input  wire [xlen-1:0]   pc,
    output id_out_t          id_out
);

    ctrl_t           ctrl_d;
    ctrl_t           ctrl_q;
    inst_u           inst_q;
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] imm;

    ctrl_decoder u_ctrl_decoder (
        .inst (instruction),
        .ctrl (ctrl_d)
    );

    imm_gen u_imm_gen (
        .inst (inst_q),
        .imm  (imm)
    );

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ctrl_q <= '0;
            inst_q <= '0;
            pc_q   <= '0;
        end else if (flush) begin       // bubble, wins over stall
            ctrl_q <= '0;
            inst_q <= '0;
            pc_q   <= '0;
        end else if (!stall) begin
            ctrl_q <= ctrl_d;
            inst_q <= instruction;
            pc_q   <= pc;
        end
    end

    // register fields sit in the same place for every format
    always_comb begin
        id_out.pc   = pc_q;
        id_out.rd   = inst_q.r_fmt.rd;
        id_out.rs1  = inst_q.r_fmt.rs1;
        id_out.rs2  = inst_q.r_fmt.rs2;
        id_out.imm  = imm;
        id_out.ctrl = ctrl_q;
    end

    // a flushed slot must not write registers or memory
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!reset)
        flush |=> (!id_out.ctrl.rf_wr_en && id_out.ctrl.dm_wr_ctrl == 3'd0)
    );

endmodule

`default_nettype wire

// File: verilog/forward_unit.sv
/*
 * forward_unit: picks each source operand from EX, then MEM, then the
 * register file. Address x0 is never forwarded.
 */
`default_nettype none

module forward_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire [4:0]        rs1,
    input  wire [4:0]        rs2,
    input  wire fwd_src_t    ex_fwd,
    input  wire fwd_src_t    mem_fwd,
    input  wire [xlen-1:0]   rf_rs1_data,
    input  wire [xlen-1:0]   rf_rs2_data,
    output logic [xlen-1:0]  rs1_data,
    output logic [xlen-1:0]  rs2_data
);

    function automatic logic [xlen-1:0] pick(input logic [4:0] addr,
                                             input logic [xlen-1:0] rf_data,
                                             input fwd_src_t ex, input fwd_src_t mem);
        if (addr == 5'd0) return rf_data;               // rf gives zero here
        if (ex.wr_en && ex.rd == addr) return ex.data;  // youngest first
        if (mem.wr_en && mem.rd == addr) return mem.data;
        return rf_data;
    endfunction

    assign rs1_data = pick(rs1, rf_rs1_data, ex_fwd, mem_fwd);
    assign rs2_data = pick(rs2, rf_rs2_data, ex_fwd, mem_fwd);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/*
 * reg_file: 32 x 64 integer register file, two asynchronous reads and one
 * write port. x0 reads zero; a same-cycle write is visible on the reads.
 */
`default_nettype none

module reg_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire [4:0]        rs1,
    input  wire [4:0]        rs2,
    input  wire fwd_src_t    wb_wr,
    output logic [xlen-1:0]  rs1_data,
    output logic [xlen-1:0]  rs2_data
);

    logic [xlen-1:0] regs [32];
    logic            wr_hit;

    assign wr_hit = wb_wr.wr_en && (wb_wr.rd != 5'd0);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb_wr.rd] <= wb_wr.data;
        end
    end

    // read side, write-through ahead of the array
    assign rs1_data = (rs1 == 5'd0)               ? '0         :
                      (wr_hit && wb_wr.rd == rs1) ? wb_wr.data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0)               ? '0         :
                      (wr_hit && wb_wr.rd == rs2) ? wb_wr.data : regs[rs2];

    // attempted writes to x0 must leave it at zero
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!reset)
        (wb_wr.wr_en && wb_wr.rd == 5'd0) |=> (regs[0] == '0)
    );

endmodule

`default_nettype wire

// File: verilog/imm_gen.sv
/*
 * imm_gen: rebuilds the sign-extended immediate of the I, S, B, U or J
 * format selected by the opcode. Other opcodes give zero.
 */
`default_nettype none

module imm_gen
    import isa_pkg::*;
(
    input  wire inst_u       inst,
    output logic [xlen-1:0]  imm
);

    always_comb begin
        case (inst.raw[6:0])
            op_jalr, op_load, op_opimm, op_opimm32, op_system:
                imm = {{52{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            op_store:
                imm = {{52{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                       inst.s_fmt.imm_4_0};
            op_branch:
                imm = {{51{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};  // halfword offset
            op_lui, op_auipc:
                imm = {{32{inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12, 12'b0};
            op_jal:
                imm = {{43{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default:
                imm = '0;  // r-type and unknown
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ctrl_decoder.sv
/*
 * ctrl_decoder: combinational table from opcode, funct3 and funct7 to the
 * pipeline control word. Unknown opcodes decode to an all-zero bubble.
 */
`default_nettype none

module ctrl_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire inst_u inst,
    output ctrl_t      ctrl
);

    logic [2:0] funct3;
    logic       f7_b5;

    assign funct3 = inst.r_fmt.funct3;
    assign f7_b5  = inst.r_fmt.funct7[5];

    // integer op from funct3; word forms only differ for add/sub
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic imm_form, input logic word);
        alu_op_e op;
        case (f3)
            f3_add_sub: begin
                if (alt && !imm_form) op = sub;  // no subi
                else op = add;
            end
            f3_sll:  op = sll;
            f3_slt:  op = slt;
            f3_sltu: op = sltu;
            f3_xor:  op = xor_op;
            f3_srl_sra: begin
                if (alt) op = sra;
                else op = srl;
            end
            f3_or:   op = or_op;
            f3_and:  op = and_op;
            default: op = add;
        endcase
        if (word && op == add) op = addw;
        if (word && op == sub) op = subw;
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        case (inst.r_fmt.opcode)
            op_op, op_op32: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.rf_wr_sel = wr_sel_alu;
                ctrl.alu_ctrl  = alu_sel(funct3, f7_b5, 1'b0, inst.r_fmt.opcode == op_op32);
            end
            op_opimm, op_opimm32: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                ctrl.alu_ctrl  = alu_sel(funct3, f7_b5, 1'b1,
                                         inst.i_fmt.opcode == op_opimm32);
            end
            op_load: begin
                ctrl.rf_wr_en   = 1'b1;
                ctrl.rf_wr_sel  = wr_sel_mem;
                ctrl.alu_b_sel  = 1'b1;
                ctrl.alu_ctrl   = add;              // base + offset
                ctrl.dm_rd_ctrl = funct3 + 3'd1;
            end
            op_store: begin
                ctrl.alu_b_sel  = 1'b1;
                ctrl.alu_ctrl   = add;
                ctrl.dm_wr_ctrl = inst.s_fmt.funct3 + 3'd1;
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_type   = inst.b_fmt.funct3;
                ctrl.alu_ctrl  = sub;               // compare rs1 - rs2
            end
            op_jal: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.rf_wr_sel = wr_sel_pc4;
                ctrl.do_jump   = 1'b1;
                ctrl.alu_a_sel = 1'b1;              // target = pc + imm
                ctrl.alu_b_sel = 1'b1;
                ctrl.alu_ctrl  = add;
            end
            op_jalr: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.rf_wr_sel = wr_sel_pc4;
                ctrl.do_jump   = 1'b1;
                ctrl.alu_b_sel = 1'b1;              // target = rs1 + imm
                ctrl.alu_ctrl  = add;
            end
            op_lui: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                ctrl.alu_ctrl  = pass_b;
            end
            op_auipc: begin
                ctrl.rf_wr_en  = 1'b1;
                ctrl.alu_a_sel = 1'b1;
                ctrl.alu_b_sel = 1'b1;
                ctrl.alu_ctrl  = add;
            end
            op_system: begin
                ctrl.is_debug = 1'b1;               // no csr support
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
/*
 * pipe_pkg: pipeline bundles passed between decode and the later stages,
 * i.e. the control word, forwarded results and the decode stage output.
 */
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // write-back data source
    localparam logic [1:0] wr_sel_alu = 2'd0;
    localparam logic [1:0] wr_sel_mem = 2'd1;
    localparam logic [1:0] wr_sel_pc4 = 2'd2;

    typedef struct packed {
        logic       rf_wr_en;
        logic [1:0] rf_wr_sel;
        logic       do_jump;
        logic       is_branch;
        logic [2:0] br_type;     // branch funct3
        logic       alu_a_sel;   // 1 = pc
        logic       alu_b_sel;   // 1 = immediate
        alu_op_e    alu_ctrl;
        logic [2:0] dm_rd_ctrl;  // 0 = none, else funct3 + 1
        logic [2:0] dm_wr_ctrl;
        logic       is_debug;
    } ctrl_t;

    // result a later stage can hand back
    typedef struct packed {
        logic            wr_en;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } fwd_src_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        ctrl_t           ctrl;
    } id_out_t;

endpackage

`default_nettype wire

// File: verilog/isa_pkg.sv
/*
 * isa_pkg: RV64I encoding definitions. Holds the opcode and funct3 codes,
 * the ALU operation set and the instruction word with its format views.
 */
`default_nettype none

package isa_pkg;

    localparam int xlen = 64;  // data path width

    // major opcodes, bits [6:0]
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_opimm   = 7'b0010011;
    localparam logic [6:0] op_op      = 7'b0110011;
    localparam logic [6:0] op_opimm32 = 7'b0011011;
    localparam logic [6:0] op_op32    = 7'b0111011;
    localparam logic [6:0] op_system  = 7'b1110011;

    // funct3 for the integer ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op, pass_b, addw, subw
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one 32-bit word, read through whichever format the opcode calls for
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        b_fmt_t      b_fmt;
        u_fmt_t      u_fmt;
        j_fmt_t      j_fmt;
    } inst_u;

endpackage

`default_nettype wire
